// ==== source/motion_overlay_pkg.sv ====
package motion_overlay_pkg;

    // raster coordinates
    // 10 bits covers 640x480 plus the blanking counts
    localparam int coord_width = 10;

    typedef logic [coord_width-1:0] coord_t;

    // one point on the screen
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // one pixel slot of the video timing
    // de high only inside the visible window
    typedef struct packed {
        logic   de;
        coord_t x;
        coord_t y;
    } raster_t;

    // one entry of the shot history
    typedef struct packed {
        logic   valid;
        point_t pos;
    } shot_mark_t;

    // frame buffer word, rgb565
    typedef logic [15:0] rgb565_t;

    // vga output colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // frame buffer is a quarter of the raster in each axis
    localparam int fb_shift = 2;
    // 160x120 entries
    localparam int fb_addr_width = $clog2(160 * 120);

    typedef logic [fb_addr_width-1:0] fb_addr_t;

    // reticle ring band, squared radii 16 and 20
    localparam int ring_inner_sq = 256;
    localparam int ring_outer_sq = 400;

    // cross arms inside the ring, half width in pixels
    localparam int cross_half_width = 2;

    // shot disc, radius 12 squared
    localparam int shot_radius_sq = 144;

    // red boost for moving pixels
    // added modulo 16, so bright reds wrap around
    localparam logic [3:0] motion_tint = 4'd3;

endpackage

// ==== source/centroid_tracker.sv ====
`timescale 1ns/10ps

module centroid_tracker #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic                        clk,
    input  logic                        reset,
    input  motion_overlay_pkg::raster_t pixel,
    input  logic                        motion_flag,
    output motion_overlay_pkg::point_t  centroid,
    output logic                        motion_valid
);
    import motion_overlay_pkg::*;

    // running sums of flagged pixel coordinates
    logic [31:0] sum_x;
    logic [31:0] sum_y;
    // number of flagged pixels this frame
    logic [31:0] count;

    logic        active;
    logic        frame_end;
    logic        hit;

    // division results, only the low bits are a coordinate
    logic [31:0] divisor;
    logic [31:0] quot_x;
    logic [31:0] quot_y;

    // visible window
    assign active = pixel.de && (pixel.x < H_ACTIVE) && (pixel.y < V_ACTIVE);

    // marker slot just past the last visible pixel
    // de is ignored here
    assign frame_end = (pixel.x == H_ACTIVE) && (pixel.y == V_ACTIVE);

    // a moving pixel that counts toward the centroid
    assign hit = active && motion_flag;

    // keep the divider away from zero
    // the result is discarded anyway when count is zero
    assign divisor = (count == 32'd0) ? 32'd1 : count;
    assign quot_x  = sum_x / divisor;
    assign quot_y  = sum_y / divisor;

    // accumulators
    // frame end and a hit never coincide, marker lies outside the window
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (frame_end) begin
            // start the next frame from scratch
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (hit) begin
            sum_x <= sum_x + 32'(pixel.x);
            sum_y <= sum_y + 32'(pixel.y);
            count <= count + 32'd1;
        end
    end

    // centroid register
    // updated once per frame, holds in between
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            centroid     <= '0;
            motion_valid <= 1'b0;
        end else if (frame_end) begin
            if (count != 32'd0) begin
                // floor of the mean
                centroid.x   <= coord_t'(quot_x);
                centroid.y   <= coord_t'(quot_y);
                motion_valid <= 1'b1;
            end else begin
                // no motion seen, park at origin
                centroid     <= '0;
                motion_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/shot_recorder.sv ====
`timescale 1ns/10ps

module shot_recorder #(
    parameter int SHOT_DEPTH = 6
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           shot_btn,
    input  motion_overlay_pkg::point_t                     centroid,
    input  logic                                           motion_valid,
    output motion_overlay_pkg::shot_mark_t [SHOT_DEPTH-1:0] shots
);
    import motion_overlay_pkg::*;

    // button synchronizer stages
    logic       btn_meta;
    logic       btn_sync;

    // one cycle pulse per rising button level
    logic       press;
    // press that actually lands in the history
    logic       record;

    // entry pushed in at slot 0
    shot_mark_t new_mark;

    // two flops, button is asynchronous to clk
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= shot_btn;
            btn_sync <= btn_meta;
        end
    end

    // rising edge of the synchronized level
    // a held button gives a single pulse
    assign press = btn_meta & ~btn_sync;

    // only record while a centroid is on screen
    assign record = press & motion_valid;

    // current aim point, marked valid
    assign new_mark.valid = 1'b1;
    assign new_mark.pos   = centroid;

    // history shift register
    // slot 0 newest, top slot drops off on each push
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // all slots invalid
            shots <= '0;
        end else if (record) begin
            shots <= {shots[SHOT_DEPTH-2:0], new_mark};
        end
    end

endmodule

// ==== source/overlay_mixer.sv ====
`timescale 1ns/10ps

module overlay_mixer #(
    parameter int H_ACTIVE   = 640,
    parameter int V_ACTIVE   = 480,
    parameter int SHOT_DEPTH = 6
) (
    input  motion_overlay_pkg::raster_t                    pixel,
    input  logic                                           motion_flag,
    input  motion_overlay_pkg::rgb565_t                    img_data,
    input  motion_overlay_pkg::point_t                     centroid,
    input  logic                                           motion_valid,
    input  motion_overlay_pkg::shot_mark_t [SHOT_DEPTH-1:0] shots,
    output motion_overlay_pkg::fb_addr_t                   fb_addr,
    output motion_overlay_pkg::rgb444_t                    rgb
);
    import motion_overlay_pkg::*;

    // frame buffer row length
    localparam int fb_cols = H_ACTIVE >> fb_shift;

    // squared distance range, two 10 bit squares summed
    localparam int dist_width = 2 * coord_width + 1;

    typedef logic [dist_width-1:0] dist_t;

    // |a - b| without going signed
    function automatic coord_t abs_diff(coord_t a, coord_t b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    // dx^2 + dy^2, widened before the multiply
    function automatic dist_t dist_sq(coord_t dx, coord_t dy);
        dist_t wx;
        dist_t wy;
        wx = dist_t'(dx);
        wy = dist_t'(dy);
        return (wx * wx) + (wy * wy);
    endfunction

    logic                  active;

    // reticle geometry
    coord_t                dx;
    coord_t                dy;
    dist_t                 d;
    logic                  on_ring;
    logic                  on_cross;
    logic                  on_reticle;

    // one bit per history slot
    logic [SHOT_DEPTH-1:0] shot_hit;

    // image reduced to 4 bits per channel
    rgb444_t               img_rgb;

    assign active = pixel.de && (pixel.x < H_ACTIVE) && (pixel.y < V_ACTIVE);

    // quarter resolution lookup
    // zero outside the window
    assign fb_addr = active ?
        fb_addr_t'(fb_cols * (pixel.y >> fb_shift) + (pixel.x >> fb_shift)) : '0;

    // distance to the centroid
    assign dx = abs_diff(pixel.x, centroid.x);
    assign dy = abs_diff(pixel.y, centroid.y);
    assign d  = dist_sq(dx, dy);

    // ring band
    assign on_ring = (d >= ring_inner_sq) && (d <= ring_outer_sq);

    // cross, clipped to the ring interior
    assign on_cross = ((dx <= cross_half_width) || (dy <= cross_half_width)) &&
                      (d <= ring_inner_sq);

    // reticle only while a centroid exists
    assign on_reticle = motion_valid && (on_ring || on_cross);

    // disc test per recorded shot
    for (genvar i = 0; i < SHOT_DEPTH; i++) begin : g_shot
        coord_t sdx;
        coord_t sdy;

        assign sdx = abs_diff(pixel.x, shots[i].pos.x);
        assign sdy = abs_diff(pixel.y, shots[i].pos.y);

        // empty slots never paint
        assign shot_hit[i] = shots[i].valid && (dist_sq(sdx, sdy) <= shot_radius_sq);
    end

    // top bits of each rgb565 channel
    assign img_rgb.r = img_data[15:12];
    assign img_rgb.g = img_data[10:7];
    assign img_rgb.b = img_data[4:1];

    // colour priority
    // reticle, then shot discs, then tinted or plain image
    always_comb begin
        rgb = '0;
        if (active) begin
            if (on_reticle) begin
                // pure red
                rgb.r = 4'hf;
                rgb.g = 4'h0;
                rgb.b = 4'h0;
            end else if (|shot_hit) begin
                // black disc
                rgb = '0;
            end else if (motion_flag) begin
                // wraps modulo 16
                rgb   = img_rgb;
                rgb.r = img_rgb.r + motion_tint;
            end else begin
                rgb = img_rgb;
            end
        end
    end

endmodule

// ==== source/motion_overlay_top.sv ====
`timescale 1ns/10ps

module motion_overlay_top #(
    parameter int H_ACTIVE   = 640,
    parameter int V_ACTIVE   = 480,
    parameter int SHOT_DEPTH = 6
) (
    input  logic                         clk,
    input  logic                         reset,
    input  motion_overlay_pkg::raster_t  pixel,
    input  logic                         motion_flag,
    input  logic                         shot_btn,
    input  motion_overlay_pkg::rgb565_t  img_data,
    output motion_overlay_pkg::fb_addr_t fb_addr,
    output motion_overlay_pkg::rgb444_t  rgb
);
    import motion_overlay_pkg::*;

    // per-frame aim point
    point_t                     centroid;
    logic                       motion_valid;

    // shot history, slot 0 newest
    shot_mark_t [SHOT_DEPTH-1:0] shots;

    // centroid of moving pixels, refreshed at each frame end
    centroid_tracker #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_tracker (
        .clk         (clk),
        .reset       (reset),
        .pixel       (pixel),
        .motion_flag (motion_flag),
        .centroid    (centroid),
        .motion_valid(motion_valid)
    );

    // button to shot history
    shot_recorder #(
        .SHOT_DEPTH(SHOT_DEPTH)
    ) u_shots (
        .clk         (clk),
        .reset       (reset),
        .shot_btn    (shot_btn),
        .centroid    (centroid),
        .motion_valid(motion_valid),
        .shots       (shots)
    );

    // combinational overlay on the image stream
    overlay_mixer #(
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .SHOT_DEPTH(SHOT_DEPTH)
    ) u_mixer (
        .pixel       (pixel),
        .motion_flag (motion_flag),
        .img_data    (img_data),
        .centroid    (centroid),
        .motion_valid(motion_valid),
        .shots       (shots),
        .fb_addr     (fb_addr),
        .rgb         (rgb)
    );

endmodule

// ==== dv/motion_overlay_properties.sv ====
`timescale 1ns/10ps

module motion_overlay_properties #(
    parameter int H_ACTIVE   = 640,
    parameter int V_ACTIVE   = 480,
    parameter int SHOT_DEPTH = 6
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  motion_overlay_pkg::raster_t                    pixel,
    input  motion_overlay_pkg::fb_addr_t                   fb_addr,
    input  motion_overlay_pkg::rgb444_t                    rgb,
    input  logic                                           motion_valid,
    input  logic                                           press,
    input  logic [31:0]                                    count,
    input  motion_overlay_pkg::shot_mark_t [SHOT_DEPTH-1:0] shots
);
    import motion_overlay_pkg::*;

    // read by the testbench
    int   failures = 0;

    logic active;
    logic frame_end;

    assign active    = pixel.de && (pixel.x < H_ACTIVE) && (pixel.y < V_ACTIVE);
    assign frame_end = (pixel.x == H_ACTIVE) && (pixel.y == V_ACTIVE);

    // blanking gives black and address 0
    blank_outside: assert property (@(posedge clk) disable iff (reset)
        !active |-> (rgb == '0) && (fb_addr == '0))
    else begin
        $error("rgb or fb_addr nonzero outside the visible window");
        failures++;
    end

    // press with no centroid, history untouched
    ignored_press: assert property (@(posedge clk) disable iff (reset)
        press && !motion_valid |=> $stable(shots))
    else begin
        $error("shot history changed on a press without a valid centroid");
        failures++;
    end

    // valid flag tracks whether the frame saw motion
    valid_at_frame_end: assert property (@(posedge clk) disable iff (reset)
        frame_end |=> (motion_valid == $past(count != 32'd0)))
    else begin
        $error("motion_valid disagrees with the count of the finished frame");
        failures++;
    end

endmodule

bind motion_overlay_top motion_overlay_properties #(
    .H_ACTIVE  (H_ACTIVE),
    .V_ACTIVE  (V_ACTIVE),
    .SHOT_DEPTH(SHOT_DEPTH)
) u_props (
    .clk         (clk),
    .reset       (reset),
    .pixel       (pixel),
    .fb_addr     (fb_addr),
    .rgb         (rgb),
    .motion_valid(motion_valid),
    .press       (u_shots.press),
    .count       (u_tracker.count),
    .shots       (shots)
);

// ==== dv/motion_overlay_tb.sv ====
`timescale 1ns/10ps

module motion_overlay_tb;
    import motion_overlay_pkg::*;

    localparam int h_active   = 640;
    localparam int v_active   = 480;
    localparam int shot_depth = 6;
    localparam int clk_period = 4;
    localparam int num_frames = 9;
    // quarter resolution frame buffer width
    localparam int fb_cols    = 160;

    // what a probe pixel should show
    localparam int kind_image = 0;
    localparam int kind_tint  = 1;
    localparam int kind_red   = 2;
    localparam int kind_black = 3;
    localparam int kind_blank = 4;

    // one table row, press 0 none, 1 tap, 2 long hold
    typedef struct packed {
        logic [2:0]   npts;
        point_t [3:0] pts;
        point_t       centroid;
        logic         valid;
        logic [1:0]   press;
    } frame_t;

    logic        clk = 1'b0;
    logic        reset;
    raster_t     pixel;
    logic        motion_flag;
    logic        shot_btn;
    rgb565_t     img_data;
    fb_addr_t    fb_addr;
    rgb444_t     rgb;

    logic [31:0] rng_state;
    frame_t      frames [num_frames];
    // expected history, newest first
    point_t      shot_model[$];
    // shots pushed out of the history
    point_t      dropped[$];
    point_t      last_centroid;

    motion_overlay_top #(
        .H_ACTIVE  (h_active),
        .V_ACTIVE  (v_active),
        .SHOT_DEPTH(shot_depth)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .pixel      (pixel),
        .motion_flag(motion_flag),
        .shot_btn   (shot_btn),
        .img_data   (img_data),
        .fb_addr    (fb_addr),
        .rgb        (rgb)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("*** FAILED ***");
        $fatal(1, reason);
    endtask

    // lcg, numerical recipes constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // rgb565 to rgb444, top bits of each channel
    function automatic rgb444_t image_to_rgb444(rgb565_t w);
        rgb444_t c;
        c.r = w[15:12];
        c.g = w[10:7];
        c.b = w[4:1];
        return c;
    endfunction

    function automatic fb_addr_t fb_index(int x, int y);
        return fb_addr_t'((y / 4) * fb_cols + (x / 4));
    endfunction

    task automatic check_rgb(input rgb444_t got, input rgb444_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: rgb (%s) got %h expected %h", $time, what, got, exp);
            abort_run("rgb mismatch");
        end
    endtask

    task automatic check_addr(input fb_addr_t got, input fb_addr_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: fb_addr (%s) got %h expected %h",
                     $time, what, got, exp);
            abort_run("fb_addr mismatch");
        end
    endtask

    // new inputs 1 ns after the edge, fresh image word each cycle
    task automatic drive(input logic de, input int x, input int y, input logic flag);
        logic [31:0] r;
        @(posedge clk);
        #1;
        r           = next_rand();
        pixel.de    = de;
        pixel.x     = coord_t'(x);
        pixel.y     = coord_t'(y);
        motion_flag = flag;
        img_data    = r[23:8];
    endtask

    task automatic blank();
        drive(1'b0, 0, 0, 1'b0);
    endtask

    // mixer is combinational, sample late in the same cycle
    task automatic probe(input logic de, input int x, input int y, input logic flag,
                         input int kind, input string what);
        rgb444_t  exp_rgb;
        fb_addr_t exp_addr;
        drive(de, x, y, flag);
        exp_addr = fb_index(x, y);
        exp_rgb  = image_to_rgb444(img_data);
        case (kind)
            kind_tint:  exp_rgb.r = exp_rgb.r + 4'd3;
            kind_red:   exp_rgb = {4'hf, 4'h0, 4'h0};
            kind_black: exp_rgb = '0;
            kind_blank: begin
                exp_rgb  = '0;
                exp_addr = '0;
            end
            default:    ;
        endcase
        #2;
        check_rgb(rgb, exp_rgb, what);
        check_addr(fb_addr, exp_addr, what);
    endtask

    task automatic set_frame(input int i, input int n, input int x0, y0, x1, y1, x2, y2,
                             input int x3, y3, cx, cy, input logic v, input logic [1:0] p);
        frames[i].npts     = 3'(n);
        frames[i].pts[0]   = {coord_t'(x0), coord_t'(y0)};
        frames[i].pts[1]   = {coord_t'(x1), coord_t'(y1)};
        frames[i].pts[2]   = {coord_t'(x2), coord_t'(y2)};
        frames[i].pts[3]   = {coord_t'(x3), coord_t'(y3)};
        frames[i].centroid = {coord_t'(cx), coord_t'(cy)};
        frames[i].valid    = v;
        frames[i].press    = p;
    endtask

    // centroids are floor of the mean, at least 80 pixels apart
    task automatic load_frames();
        set_frame(0, 3, 100, 100, 102, 101, 101, 103, 0, 0, 101, 101, 1'b1, 2'd1);
        // long hold, must land once only
        set_frame(1, 2, 200, 150, 203, 152, 0, 0, 0, 0, 201, 151, 1'b1, 2'd2);
        set_frame(2, 4, 300, 100, 301, 100, 302, 101, 304, 102, 301, 100, 1'b1, 2'd1);
        set_frame(3, 1, 400, 200, 0, 0, 0, 0, 0, 0, 400, 200, 1'b1, 2'd1);
        set_frame(4, 3, 500, 300, 503, 301, 501, 302, 0, 0, 501, 301, 1'b1, 2'd1);
        set_frame(5, 2, 100, 300, 101, 301, 0, 0, 0, 0, 100, 300, 1'b1, 2'd1);
        // seventh shot pushes the first one out
        set_frame(6, 2, 300, 300, 300, 302, 0, 0, 0, 0, 300, 301, 1'b1, 2'd1);
        // empty frame, its press is ignored
        set_frame(7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1'b0, 2'd1);
        set_frame(8, 2, 500, 100, 502, 102, 0, 0, 0, 0, 501, 101, 1'b1, 2'd0);
    endtask

    task automatic press_button(input int hold);
        blank();
        shot_btn = 1'b1;
        repeat (hold) blank();
        shot_btn = 1'b0;
        // sync stages plus shift register
        repeat (4) blank();
    endtask

    task automatic check_passthrough(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            probe(1'b1, int'(r[31:20]) % h_active, int'(r[19:8]) % v_active, 1'b0,
                  kind_image, "passthrough");
        end
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            probe(1'b0, int'(r[31:20]) % h_active, int'(r[19:8]) % v_active, 1'b0,
                  kind_blank, "de low");
            probe(1'b1, h_active + int'(r[7:0]) % 160, int'(r[19:8]) % v_active, 1'b0,
                  kind_blank, "x past window");
            probe(1'b1, int'(r[31:20]) % h_active, v_active + int'(r[7:0]) % 40, 1'b0,
                  kind_blank, "y past window");
        end
    endtask

    task automatic check_tint(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            probe(1'b1, int'(r[31:20]) % h_active, int'(r[19:8]) % v_active, 1'b1,
                  kind_tint, "motion tint");
        end
        // frame end so the table starts with clean sums
        drive(1'b0, h_active, v_active, 1'b0);
    endtask

    task automatic run_frame(input int i);
        frame_t f;
        int     cx;
        int     cy;
        f  = frames[i];
        cx = int'(f.centroid.x);
        cy = int'(f.centroid.y);
        for (int k = 0; k < f.npts; k++)
            drive(1'b1, int'(f.pts[k].x), int'(f.pts[k].y), 1'b1);
        drive(1'b0, h_active, v_active, 1'b0);
        if (f.valid) begin
            probe(1'b1, cx, cy, 1'b0, kind_red, "reticle centre");
            probe(1'b1, cx + 18, cy, 1'b0, kind_red, "reticle ring");
            // ring edges at radius 20 pin the centroid exactly
            probe(1'b1, cx + 20, cy, 1'b0, kind_red, "ring right edge");
            probe(1'b1, cx - 20, cy, 1'b0, kind_red, "ring left edge");
            probe(1'b1, cx, cy + 20, 1'b0, kind_red, "ring bottom edge");
            probe(1'b1, cx, cy - 20, 1'b0, kind_red, "ring top edge");
            probe(1'b1, cx + 21, cy, 1'b0, kind_image, "outside ring");
            probe(1'b1, cx + 7, cy + 7, 1'b0, kind_image, "inside ring");
            last_centroid = f.centroid;
        end else begin
            probe(1'b1, cx, cy, 1'b0, kind_image, "centre after empty frame");
            probe(1'b1, cx + 18, cy, 1'b0, kind_image, "ring after empty frame");
        end
        // a shot recorded without motion would sit at the origin
        probe(1'b1, 8, 8, 1'b0, kind_image, "no disc at origin");
        foreach (shot_model[k])
            probe(1'b1, shot_model[k].x + 8, shot_model[k].y + 8, 1'b0, kind_black, "shot disc");
        foreach (dropped[k])
            probe(1'b1, dropped[k].x + 8, dropped[k].y + 8, 1'b0, kind_image, "dropped shot");
        if (f.press != 2'd0) begin
            press_button((f.press == 2'd2) ? 30 : 3);
            if (f.valid) begin
                shot_model.push_front(f.centroid);
                if (shot_model.size() > shot_depth)
                    dropped.push_back(shot_model.pop_back());
            end
        end
    endtask

    task automatic reset_mid_run();
        blank();
        reset = 1'b1;
        repeat (4) blank();
        reset = 1'b0;
        probe(1'b1, last_centroid.x, last_centroid.y, 1'b0, kind_image, "centre after reset");
        probe(1'b1, last_centroid.x + 18, last_centroid.y, 1'b0, kind_image, "ring after reset");
        foreach (shot_model[k])
            probe(1'b1, shot_model[k].x + 8, shot_model[k].y + 8, 1'b0, kind_image,
                  "disc after reset");
        shot_model.delete();
        dropped.delete();
    endtask

    // bound assertions bump a counter, stop at the first one
    always @(negedge clk) begin
        if (u_dut.u_props.failures != 0) begin
            $display("a bound assertion failed before %0t", $time);
            abort_run("assertion failure");
        end
    end

    initial begin
        #(num_frames * 200 * clk_period);
        $display("timeout, the test sequence did not finish within the watchdog limit");
        abort_run("watchdog expired");
    end

    initial begin
        rng_state   = 32'd9;
        reset       = 1'b1;
        pixel       = '0;
        motion_flag = 1'b0;
        shot_btn    = 1'b0;
        img_data    = '0;
        load_frames();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_passthrough(24);
        check_tint(12);
        for (int i = 0; i < num_frames; i++)
            run_frame(i);
        reset_mid_run();
        check_passthrough(24);
        blank();
        if (u_dut.u_props.failures == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("bound assertion reported a failure");
        end
    end

endmodule

// ==== tb.f ====
source/motion_overlay_pkg.sv
source/centroid_tracker.sv
source/shot_recorder.sv
source/overlay_mixer.sv
source/motion_overlay_top.sv
dv/motion_overlay_properties.sv
dv/motion_overlay_tb.sv

// ==== Bender.yml ====
package:
  name: motion_overlay

sources:
  - files:
      - source/motion_overlay_pkg.sv
      - source/centroid_tracker.sv
      - source/shot_recorder.sv
      - source/overlay_mixer.sv
      - source/motion_overlay_top.sv
  - target: simulation
    files:
      - dv/motion_overlay_properties.sv
      - dv/motion_overlay_tb.sv
